// ==== logic/mapper_pkg.sv ====
/* Shared types, field widths, mapper numbers and memory region bits
   for the discrete mapper core */
package mapper_pkg;

	// Bus widths
	localparam int CPU_ADDR_BITS  = 16;	// CPU address bus
	localparam int PPU_ADDR_BITS  = 14;	// PPU address bus
	localparam int MEM_ADDR_BITS  = 22;	// 4 MiB cartridge memory
	localparam int DATA_BITS      = 8;	// CPU data bus
	localparam int MAPPER_ID_BITS = 8;	// iNES mapper number

	// Address and data types
	typedef logic [CPU_ADDR_BITS-1:0]  cpu_addr_t;	// CPU side (PRG)
	typedef logic [PPU_ADDR_BITS-1:0]  ppu_addr_t;	// PPU side (CHR)
	typedef logic [MEM_ADDR_BITS-1:0]  mem_addr_t;	// Shared memory address
	typedef logic [DATA_BITS-1:0]      data_t;	// CPU data byte
	typedef logic [MAPPER_ID_BITS-1:0] mapper_id_t;	// Mapper select

	// Supported mapper numbers
	localparam mapper_id_t MAPPER_NROM     = 8'd0;	// No mapper chip
	localparam mapper_id_t MAPPER_BXROM    = 8'd34;	// BxROM oversize
	localparam mapper_id_t MAPPER_GXROM    = 8'd66;	// GxROM
	localparam mapper_id_t MAPPER_CAMERICA = 8'd71;	// Camerica and Fire Hawk

	// Offset widths inside the bank windows
	localparam int PRG_WINDOW_BITS = 15;	// 32 KiB PRG window
	localparam int PRG_HALF_BITS   = 14;	// 16 KiB PRG half
	localparam int CHR_WINDOW_BITS = 13;	// 8 KiB CHR window

	// Memory regions
	// PRG ROM starts at address zero of the shared memory and CHR sits in the
	// upper 2 MiB, so a single address bit tells the two regions apart
	localparam int CHR_ROM_BASE_BIT = 21;	// Set for every CHR access

endpackage

// ==== logic/bank_registers.sv ====
`timescale 1ns/1ns

/* CPU write decode and bank register file
   PRG bank, CHR bank and Camerica single-screen select */
module bank_registers #(
	parameter int PRG_BANK_BITS = 6,	// PRG bank register width
	parameter int CHR_BANK_BITS = 2	// CHR bank register width
) (
	input  logic                      clk,
	input  logic                      rst,	// Sync, active high
	input  logic                      ce,	// CPU cycle enable
	input  logic                      prg_write,	// CPU write strobe
	input  mapper_pkg::cpu_addr_t     prg_ain,	// CPU address
	input  mapper_pkg::data_t         prg_din,	// CPU write data
	input  mapper_pkg::mapper_id_t    mapper_id,	// Selected mapper
	output logic [PRG_BANK_BITS-1:0]  prg_bank,	// Current PRG bank
	output logic [CHR_BANK_BITS-1:0]  chr_bank,	// Current CHR bank
	output logic                      ciram_select	// Single-screen page
);

	logic                     write_cycle;	// Accepted write to $8000-$FFFF
	logic                     is_bxrom;
	logic                     is_gxrom;
	logic                     is_camerica;
	logic                     cam_mirror_hit;	// $8000-$9FFF
	logic                     cam_bank_hit;	// $C000-$FFFF
	logic                     prg_we;	// PRG bank load
	logic [PRG_BANK_BITS-1:0] prg_wdata;
	logic                     chr_we;	// CHR bank load
	logic [CHR_BANK_BITS-1:0] chr_wdata;
	logic                     ciram_we;	// Mirroring page load

	// Only ROM space writes in an enabled CPU cycle reach the registers
	assign write_cycle = ce && prg_write && prg_ain[15];

	assign is_bxrom    = (mapper_id == mapper_pkg::MAPPER_BXROM);
	assign is_gxrom    = (mapper_id == mapper_pkg::MAPPER_GXROM);
	assign is_camerica = (mapper_id == mapper_pkg::MAPPER_CAMERICA);

	// Camerica splits ROM space into two register windows
	assign cam_mirror_hit = (prg_ain[14:13] == 2'b00);	// Fire Hawk page
	assign cam_bank_hit   = prg_ain[14];	// 16K bank select

	// Per-mapper field extraction
	always_comb begin
		prg_we    = 1'b0;
		prg_wdata = '0;
		chr_we    = 1'b0;
		chr_wdata = '0;
		ciram_we  = 1'b0;
		if (write_cycle) begin
			if (is_bxrom) begin
				prg_we    = 1'b1;
				prg_wdata = PRG_BANK_BITS'(prg_din[5:0]);	// Full 6-bit oversize field
			end else if (is_gxrom) begin
				prg_we    = 1'b1;
				prg_wdata = PRG_BANK_BITS'(prg_din[5:4]);	// 32K PRG bank
				chr_we    = 1'b1;
				chr_wdata = CHR_BANK_BITS'(prg_din[1:0]);	// 8K CHR bank
			end else if (is_camerica) begin
				ciram_we  = cam_mirror_hit;
				prg_we    = cam_bank_hit;
				prg_wdata = PRG_BANK_BITS'(prg_din[3:0]);	// Lower 16K half
			end
			// NROM has no registers
		end
	end

	// Register file
	always_ff @(posedge clk) begin
		if (rst) begin
			prg_bank     <= '0;
			chr_bank     <= '0;
			ciram_select <= 1'b0;
		end else begin
			if (prg_we)
				prg_bank <= prg_wdata;
			if (chr_we)
				chr_bank <= chr_wdata;
			if (ciram_we)
				ciram_select <= prg_din[4];	// Upper or lower nametable
		end
	end

endmodule

// ==== logic/prg_address_map.sv ====
`timescale 1ns/1ns

/* CPU to PRG ROM address translation
   and PRG read permission */
module prg_address_map #(
	parameter int PRG_BANK_BITS = 6	// PRG bank register width
) (
	input  mapper_pkg::cpu_addr_t     prg_ain,	// CPU address
	input  logic                      prg_write,	// CPU write strobe
	input  mapper_pkg::mapper_id_t    mapper_id,	// Selected mapper
	input  logic [PRG_BANK_BITS-1:0]  prg_bank,	// From register file
	output mapper_pkg::mem_addr_t     prg_aout,	// PRG ROM address
	output logic                      prg_allow	// Memory access permitted
);

	localparam int         HALF_BANK_BITS = 4;	// Camerica 16K bank field
	localparam logic [3:0] LAST_HALF_BANK = 4'b1111;	// Fixed upper half
	localparam int PRG_WINDOW_BITS_L = mapper_pkg::PRG_WINDOW_BITS;

	logic [PRG_WINDOW_BITS_L-1:0] window_offset;
	logic [mapper_pkg::PRG_HALF_BITS-1:0] half_offset;
	logic [HALF_BANK_BITS-1:0] half_bank;	// Camerica bank for this access

	assign window_offset = prg_ain[PRG_WINDOW_BITS_L-1:0];
	assign half_offset   = prg_ain[mapper_pkg::PRG_HALF_BITS-1:0];

	// $8000-$BFFF switchable, $C000-$FFFF pinned to the last bank
	assign half_bank = prg_ain[14] ? LAST_HALF_BANK : HALF_BANK_BITS'(prg_bank);

	always_comb begin
		case (mapper_id)
			mapper_pkg::MAPPER_BXROM,
			mapper_pkg::MAPPER_GXROM:
				prg_aout = mapper_pkg::mem_addr_t'({prg_bank, window_offset});	// 32K banks
			mapper_pkg::MAPPER_CAMERICA:
				prg_aout = mapper_pkg::mem_addr_t'({half_bank, half_offset});	// 16K banks
			default:
				prg_aout = mapper_pkg::mem_addr_t'(window_offset);	// Fixed 32K image
		endcase
	end

	// ROM is read only
	assign prg_allow = prg_ain[15] && !prg_write;

endmodule

// ==== logic/chr_address_map.sv ====
`timescale 1ns/1ns

/* PPU to CHR address translation, nametable VRAM select,
   A10 mirroring line and CHR write permission */
module chr_address_map #(
	parameter int CHR_BANK_BITS = 2	// CHR bank register width
) (
	input  mapper_pkg::ppu_addr_t     chr_ain,	// PPU address
	input  mapper_pkg::mapper_id_t    mapper_id,	// Selected mapper
	input  logic [CHR_BANK_BITS-1:0]  chr_bank,	// From register file
	input  logic                      ciram_select,	// Single-screen page
	input  logic                      mirror_vertical,	// Header mirroring bit
	input  logic                      chr_is_ram,	// CHR is writable RAM
	output mapper_pkg::mem_addr_t     chr_aout,	// CHR memory address
	output logic                      chr_allow,	// CHR write permitted
	output logic                      vram_ce,	// Route to internal VRAM
	output logic                      vram_a10	// Nametable A10
);

	localparam int WIN_BITS = mapper_pkg::CHR_WINDOW_BITS;

	logic                     is_gxrom;
	logic                     is_camerica;
	logic [CHR_BANK_BITS-1:0] bank_field;	// Bank bits above the 8K offset
	logic [WIN_BITS-1:0]      chr_offset;

	assign is_gxrom    = (mapper_id == mapper_pkg::MAPPER_GXROM);
	assign is_camerica = (mapper_id == mapper_pkg::MAPPER_CAMERICA);

	assign chr_offset = chr_ain[WIN_BITS-1:0];
	assign bank_field = is_gxrom ? chr_bank : '0;	// Others have a fixed 8K

	// CHR region flag, then bank, then offset
	always_comb begin
		chr_aout = '0;
		chr_aout[mapper_pkg::CHR_ROM_BASE_BIT] = 1'b1;
		chr_aout = chr_aout
			| (mapper_pkg::mem_addr_t'(bank_field) << WIN_BITS)
			| mapper_pkg::mem_addr_t'(chr_offset);
	end

	// $2000-$3FFF goes to the console's own 2K VRAM
	assign vram_ce = chr_ain[WIN_BITS];

	assign chr_allow = chr_is_ram;

	// Fire Hawk is the only Camerica title with horizontal in its header,
	// so that case selects the register driven single-screen page instead
	always_comb begin
		if (mirror_vertical)
			vram_a10 = chr_ain[10];	// Vertical
		else if (is_camerica)
			vram_a10 = ciram_select;	// Single screen
		else
			vram_a10 = chr_ain[11];	// Horizontal
	end

endmodule

// ==== logic/discrete_mapper_top.sv ====
`timescale 1ns/1ns

/* Discrete mapper core for NROM, BxROM, GxROM and Camerica
   with register file and both address maps */
module discrete_mapper_top #(
	parameter int PRG_BANK_BITS = 6,	// 6 covers oversize BxROM
	parameter int CHR_BANK_BITS = 2	// GxROM CHR bank width
) (
	input  logic                   clk,
	input  logic                   rst,	// Sync, active high
	input  logic                   ce,	// CPU cycle enable
	input  mapper_pkg::cpu_addr_t  prg_ain,	// CPU address
	input  logic                   prg_write,	// CPU write strobe
	input  mapper_pkg::data_t      prg_din,	// CPU write data
	input  mapper_pkg::ppu_addr_t  chr_ain,	// PPU address
	input  mapper_pkg::mapper_id_t mapper_id,	// iNES mapper number
	input  logic                   mirror_vertical,	// Header mirroring bit
	input  logic                   chr_is_ram,	// CHR is RAM
	output mapper_pkg::mem_addr_t  prg_aout,	// PRG memory address
	output logic                   prg_allow,	// PRG access permitted
	output mapper_pkg::mem_addr_t  chr_aout,	// CHR memory address
	output logic                   chr_allow,	// CHR write permitted
	output logic                   vram_ce,	// Internal VRAM select
	output logic                   vram_a10	// Nametable A10
);

	logic [PRG_BANK_BITS-1:0] prg_bank;	// Registered bank state
	logic [CHR_BANK_BITS-1:0] chr_bank;
	logic                     ciram_select;

	bank_registers #(
		.PRG_BANK_BITS (PRG_BANK_BITS),
		.CHR_BANK_BITS (CHR_BANK_BITS)
	) bank_registers_i (
		.clk          (clk),
		.rst          (rst),
		.ce           (ce),
		.prg_write    (prg_write),
		.prg_ain      (prg_ain),
		.prg_din      (prg_din),
		.mapper_id    (mapper_id),
		.prg_bank     (prg_bank),
		.chr_bank     (chr_bank),
		.ciram_select (ciram_select)
	);

	// Combinational CPU side
	prg_address_map #(
		.PRG_BANK_BITS (PRG_BANK_BITS)
	) prg_address_map_i (
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.mapper_id (mapper_id),
		.prg_bank  (prg_bank),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow)
	);

	// Combinational PPU side
	chr_address_map #(
		.CHR_BANK_BITS (CHR_BANK_BITS)
	) chr_address_map_i (
		.chr_ain         (chr_ain),
		.mapper_id       (mapper_id),
		.chr_bank        (chr_bank),
		.ciram_select    (ciram_select),
		.mirror_vertical (mirror_vertical),
		.chr_is_ram      (chr_is_ram),
		.chr_aout        (chr_aout),
		.chr_allow       (chr_allow),
		.vram_ce         (vram_ce),
		.vram_a10        (vram_a10)
	);

endmodule

// ==== verification/discrete_mapper_properties.sv ====
`timescale 1ns/1ns

/* Concurrent checks on the discrete mapper top level
   permissions, VRAM select and register reset */
module discrete_mapper_properties #(
	parameter int PRG_BANK_BITS = 6,	// Matches the bound top level
	parameter int CHR_BANK_BITS = 2
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     prg_write,
	input  logic                     prg_allow,
	input  mapper_pkg::ppu_addr_t    chr_ain,
	input  logic                     vram_ce,
	input  logic [PRG_BANK_BITS-1:0] prg_bank,
	input  logic [CHR_BANK_BITS-1:0] chr_bank,
	input  logic                     ciram_select
);

	int assertion_failures = 0;	// Read by the testbench at the end

	// ROM is never opened to a CPU write
	no_allow_on_write: assert property (@(posedge clk) prg_write |-> !prg_allow)
		else begin
			$error("PRG access was allowed during a CPU write");
			assertion_failures++;
		end

	vram_select: assert property (@(posedge clk) vram_ce == chr_ain[13])
		else begin
			$error("VRAM select does not follow PPU address bit 13");
			assertion_failures++;
		end

	// One reset cycle clears every bank register
	reset_clears_banks: assert property (@(posedge clk)
		rst |=> (prg_bank == '0 && chr_bank == '0 && !ciram_select))
		else begin
			$error("Bank registers not cleared after reset");
			assertion_failures++;
		end

endmodule

bind discrete_mapper_top discrete_mapper_properties #(
	.PRG_BANK_BITS (PRG_BANK_BITS),
	.CHR_BANK_BITS (CHR_BANK_BITS)
) discrete_mapper_properties_i (
	.clk          (clk),
	.rst          (rst),
	.prg_write    (prg_write),
	.prg_allow    (prg_allow),
	.chr_ain      (chr_ain),
	.vram_ce      (vram_ce),
	.prg_bank     (prg_bank),
	.chr_bank     (chr_bank),
	.ciram_select (ciram_select)
);

// ==== verification/discrete_mapper_tb.sv ====
`timescale 1ns/1ns

/* Testbench for the discrete mapper core: clock, reset, stimulus,
   shadow registers, reference model, output comparison and timeout */
module discrete_mapper_tb;

	localparam int PRG_BANK_BITS = 6;
	localparam int CHR_BANK_BITS = 2;
	localparam int RESET_CYCLES  = 10;
	localparam int VECTORS       = 300;	// Random vectors per test
	localparam int PROBE_VECTORS = 4;	// Read-only vectors per probe mapper
	localparam int NUM_TESTS     = 6;
	localparam int TEST_CYCLES   = RESET_CYCLES + VECTORS + 2;	// Reset, vectors, wrap up
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 2);

	// Expected top level outputs
	typedef struct packed {
		mapper_pkg::mem_addr_t prg_aout;
		logic                  prg_allow;
		mapper_pkg::mem_addr_t chr_aout;
		logic                  chr_allow;
		logic                  vram_ce;
		logic                  vram_a10;
	} expected_t;

	logic                   clk;
	logic                   rst;
	logic                   ce;
	mapper_pkg::cpu_addr_t  prg_ain;
	logic                   prg_write;
	mapper_pkg::data_t      prg_din;
	mapper_pkg::ppu_addr_t  chr_ain;
	mapper_pkg::mapper_id_t mapper_id;
	logic                   mirror_vertical;
	logic                   chr_is_ram;
	mapper_pkg::mem_addr_t  prg_aout;
	logic                   prg_allow;
	mapper_pkg::mem_addr_t  chr_aout;
	logic                   chr_allow;
	logic                   vram_ce;
	logic                   vram_a10;

	logic [PRG_BANK_BITS-1:0] shadow_prg_bank;	// Model of the register file
	logic [CHR_BANK_BITS-1:0] shadow_chr_bank;
	logic                     shadow_ciram;

	string       current_test = "init";
	logic        check_enable = 1'b0;	// Off while a test is in reset
	int          test_errors  = 0;
	int          test_checks  = 0;
	int          total_errors = 0;
	int          total_checks = 0;
	int          tests_run    = 0;
	int          cycle_count  = 0;
	int unsigned seed_value;
	expected_t   exp_out;

	discrete_mapper_top #(
		.PRG_BANK_BITS (PRG_BANK_BITS),
		.CHR_BANK_BITS (CHR_BANK_BITS)
	) discrete_mapper_top_i (
		.clk             (clk),
		.rst             (rst),
		.ce              (ce),
		.prg_ain         (prg_ain),
		.prg_write       (prg_write),
		.prg_din         (prg_din),
		.chr_ain         (chr_ain),
		.mapper_id       (mapper_id),
		.mirror_vertical (mirror_vertical),
		.chr_is_ram      (chr_is_ram),
		.prg_aout        (prg_aout),
		.prg_allow       (prg_allow),
		.chr_aout        (chr_aout),
		.chr_allow       (chr_allow),
		.vram_ce         (vram_ce),
		.vram_a10        (vram_a10)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 100 MHz
	end

	// Expected outputs from register state and current inputs
	function automatic expected_t expected_outputs(
		input mapper_pkg::mapper_id_t   mapper,
		input mapper_pkg::cpu_addr_t    cpu_addr,
		input logic                     cpu_write,
		input mapper_pkg::ppu_addr_t    ppu_addr,
		input logic                     vertical,
		input logic                     chr_ram,
		input logic [PRG_BANK_BITS-1:0] prg_bank,
		input logic [CHR_BANK_BITS-1:0] chr_bank,
		input logic                     ciram
	);
		expected_t  e;
		logic [3:0] half_bank;
		e = '0;
		half_bank = cpu_addr[14] ? 4'hf : prg_bank[3:0];	// Upper half is fixed
		case (mapper)
			mapper_pkg::MAPPER_BXROM,
			mapper_pkg::MAPPER_GXROM:
				e.prg_aout = 22'(prg_bank) * 22'd32768 + 22'(cpu_addr[14:0]);
			mapper_pkg::MAPPER_CAMERICA:
				e.prg_aout = 22'(half_bank) * 22'd16384 + 22'(cpu_addr[13:0]);
			default:
				e.prg_aout = 22'(cpu_addr[14:0]);
		endcase
		e.prg_allow = cpu_addr[15] && !cpu_write;
		e.chr_aout  = 22'h200000 + 22'(ppu_addr[12:0]);	// CHR region at 2 MiB
		if (mapper == mapper_pkg::MAPPER_GXROM)
			e.chr_aout = e.chr_aout + 22'(chr_bank) * 22'd8192;
		e.chr_allow = chr_ram;
		e.vram_ce   = ppu_addr[13];
		if (vertical)
			e.vram_a10 = ppu_addr[10];
		else if (mapper == mapper_pkg::MAPPER_CAMERICA)
			e.vram_a10 = ciram;	// Fire Hawk page
		else
			e.vram_a10 = ppu_addr[11];
		return e;
	endfunction

	// Shadow registers follow the write rule
	always @(posedge clk) begin
		if (rst) begin
			shadow_prg_bank <= '0;
			shadow_chr_bank <= '0;
			shadow_ciram    <= 1'b0;
		end else if (ce && prg_write && prg_ain[15]) begin
			case (mapper_id)
				mapper_pkg::MAPPER_BXROM:
					shadow_prg_bank <= PRG_BANK_BITS'(prg_din[5:0]);
				mapper_pkg::MAPPER_GXROM: begin
					shadow_prg_bank <= PRG_BANK_BITS'(prg_din[5:4]);
					shadow_chr_bank <= CHR_BANK_BITS'(prg_din[1:0]);
				end
				mapper_pkg::MAPPER_CAMERICA: begin
					if (prg_ain[14:13] == 2'b00)
						shadow_ciram <= prg_din[4];	// $8000-$9FFF
					if (prg_ain[14])
						shadow_prg_bank <= PRG_BANK_BITS'(prg_din[3:0]);	// $C000-$FFFF
				end
				default: ;	// NROM ignores writes
			endcase
		end
	end

	// Compare on the falling edge, inputs and registers are settled
	always @(negedge clk) begin
		if (check_enable && !rst) begin
			exp_out = expected_outputs(mapper_id, prg_ain, prg_write, chr_ain,
				mirror_vertical, chr_is_ram, shadow_prg_bank, shadow_chr_bank, shadow_ciram);
			test_checks++;
			assert (prg_aout === exp_out.prg_aout) else begin
				$display("ERROR %s prg_aout expected %h actual %h",
					current_test, exp_out.prg_aout, prg_aout);
				test_errors++;
			end
			assert (prg_allow === exp_out.prg_allow) else begin
				$display("ERROR %s prg_allow expected %b actual %b",
					current_test, exp_out.prg_allow, prg_allow);
				test_errors++;
			end
			assert (chr_aout === exp_out.chr_aout) else begin
				$display("ERROR %s chr_aout expected %h actual %h",
					current_test, exp_out.chr_aout, chr_aout);
				test_errors++;
			end
			assert (chr_allow === exp_out.chr_allow) else begin
				$display("ERROR %s chr_allow expected %b actual %b",
					current_test, exp_out.chr_allow, chr_allow);
				test_errors++;
			end
			assert (vram_ce === exp_out.vram_ce) else begin
				$display("ERROR %s vram_ce expected %b actual %b",
					current_test, exp_out.vram_ce, vram_ce);
				test_errors++;
			end
			assert (vram_a10 === exp_out.vram_a10) else begin
				$display("ERROR %s vram_a10 expected %b actual %b",
					current_test, exp_out.vram_a10, vram_a10);
				test_errors++;
			end
		end
	end

	// One vector, applied just after the rising edge
	task automatic drive(
		input mapper_pkg::cpu_addr_t cpu_addr,
		input logic                  cpu_write,
		input mapper_pkg::data_t     cpu_data,
		input logic                  cpu_ce,
		input mapper_pkg::ppu_addr_t ppu_addr,
		input logic                  vertical,
		input logic                  chr_ram
	);
		@(posedge clk);
		prg_ain         <= cpu_addr;
		prg_write       <= cpu_write;
		prg_din         <= cpu_data;
		ce              <= cpu_ce;
		chr_ain         <= ppu_addr;
		mirror_vertical <= vertical;
		chr_is_ram      <= chr_ram;
	endtask

	task automatic random_cycle(input int write_pct);
		logic w;
		logic c;
		w = ($urandom % 100) < write_pct;
		c = ($urandom % 4) != 0;	// CPU enable three cycles of four
		drive(mapper_pkg::cpu_addr_t'($urandom), w, mapper_pkg::data_t'($urandom), c,
			mapper_pkg::ppu_addr_t'($urandom), 1'($urandom), 1'($urandom));
	endtask

	function automatic mapper_pkg::mapper_id_t pick_mapper(input int unsigned idx);
		case (idx % 4)
			0:       return mapper_pkg::MAPPER_NROM;
			1:       return mapper_pkg::MAPPER_BXROM;
			2:       return mapper_pkg::MAPPER_GXROM;
			default: return mapper_pkg::MAPPER_CAMERICA;
		endcase
	endfunction

	// Reset the DUT and select the mapper under test
	task automatic start_test(input string name, input mapper_pkg::mapper_id_t mapper);
		check_enable = 1'b0;
		current_test = name;
		test_errors  = 0;
		test_checks  = 0;
		@(posedge clk);
		rst       <= 1'b1;
		mapper_id <= mapper;
		prg_write <= 1'b0;
		ce        <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		check_enable = 1'b1;
	endtask

	task automatic finish_test();
		@(posedge clk);	// Lets the last vector be compared
		if (test_errors == 0)
			$display("test %-10s ok, %0d checks", current_test, test_checks);
		else
			$display("test %-10s has %0d errors in %0d checks", current_test, test_errors,
				test_checks);
		total_errors += test_errors;
		total_checks += test_checks;
		tests_run++;
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		seed_value      = $urandom(32'he0e7);
		rst             = 1'b1;
		ce              = 1'b0;
		prg_ain         = '0;
		prg_write       = 1'b0;
		prg_din         = '0;
		chr_ain         = '0;
		mapper_id       = mapper_pkg::MAPPER_NROM;
		mirror_vertical = 1'b0;
		chr_is_ram      = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);

		// NROM writes, then banked mappers read back the untouched registers
		start_test("nrom", mapper_pkg::MAPPER_NROM);
		repeat (VECTORS - 2 * PROBE_VECTORS) random_cycle(50);
		mapper_id <= mapper_pkg::MAPPER_GXROM;	// PRG and CHR bank visible
		repeat (PROBE_VECTORS) random_cycle(0);
		mapper_id <= mapper_pkg::MAPPER_CAMERICA;	// Single-screen page visible
		repeat (PROBE_VECTORS) random_cycle(0);
		finish_test();

		start_test("bxrom", mapper_pkg::MAPPER_BXROM);
		repeat (VECTORS) random_cycle(25);
		finish_test();

		start_test("gxrom", mapper_pkg::MAPPER_GXROM);
		repeat (VECTORS) random_cycle(25);
		finish_test();

		start_test("camerica", mapper_pkg::MAPPER_CAMERICA);
		repeat (VECTORS) random_cycle(30);
		finish_test();

		// Fire Hawk page writes, then plain mirroring on GxROM
		start_test("mirroring", mapper_pkg::MAPPER_CAMERICA);
		repeat (VECTORS / 2)
			drive({3'b100, 13'($urandom)}, ($urandom % 2) == 0, mapper_pkg::data_t'($urandom),
				1'b1, mapper_pkg::ppu_addr_t'($urandom), 1'($urandom), 1'($urandom));
		mapper_id <= mapper_pkg::MAPPER_GXROM;
		repeat (VECTORS / 2) random_cycle(20);
		finish_test();

		start_test("permission", mapper_pkg::MAPPER_BXROM);
		repeat (VECTORS) begin
			random_cycle(50);
			mapper_id <= pick_mapper($urandom);	// Same edge as the vector
		end
		finish_test();

		total_errors += discrete_mapper_top_i.discrete_mapper_properties_i.assertion_failures;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests_run,
			total_checks, total_errors,
			discrete_mapper_top_i.discrete_mapper_properties_i.assertion_failures);
		if (total_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/mapper_pkg.sv
logic/bank_registers.sv
logic/prg_address_map.sv
logic/chr_address_map.sv
logic/discrete_mapper_top.sv
verification/discrete_mapper_properties.sv
verification/discrete_mapper_tb.sv

// ==== Bender.yml ====
package:
  name: discrete_mapper

sources:
  # Design
  - files:
      - logic/mapper_pkg.sv
      - logic/bank_registers.sv
      - logic/prg_address_map.sv
      - logic/chr_address_map.sv
      - logic/discrete_mapper_top.sv

  # Verification
  - target: test
    files:
      - verification/discrete_mapper_properties.sv
      - verification/discrete_mapper_tb.sv
